/* include/vga_config.svh */
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// reduced video mode so a whole frame is only 84 positions
// for 640x480 use 640/16/96/48/800 and 480/10/2/33/525

// horizontal timing in pixels
`define VGA_H_VISIBLE      8
`define VGA_H_FRONT_PORCH  1
`define VGA_H_SYNC_PULSE   2
`define VGA_H_BACK_PORCH   1
`define VGA_H_WHOLE_LINE   12

// vertical timing in lines
`define VGA_V_VISIBLE      4
`define VGA_V_FRONT_PORCH  1
`define VGA_V_SYNC_PULSE   1
`define VGA_V_BACK_PORCH   1
`define VGA_V_WHOLE_FRAME  7

// frame buffer word address and word width
`define VGA_FB_ADDR_BITS   6
`define VGA_FB_DATA_BITS   16

// context FIFO depth is 2**VGA_FIFO_ADDR_BITS
`define VGA_FIFO_ADDR_BITS 3

// free slots left when almost_full rises
`define VGA_FIFO_ALMOST_FULL_BUF 2

// cycles from an accepted read address to rvalid
`define VGA_SRAM_READ_LATENCY 2

`endif

/* logic/fb_sram.sv */
`timescale 1ns/1ps

`include "vga_config.svh"

module fb_sram (
  input  logic                  clk,
  input  logic                  reset,

  // fill port, used while scan-out is stopped
  input  logic                  wr_en,
  input  vga_pkg::fb_addr_t     wr_addr,
  input  vga_pkg::fb_data_t     wr_data,

  // read slave
  input  vga_pkg::fb_read_req_t rd_req,
  output logic                  arready,
  input  logic                  rready,
  output vga_pkg::fb_read_rsp_t rd_rsp
);

  localparam int LATENCY = `VGA_SRAM_READ_LATENCY;
  localparam int WORDS   = 2 ** `VGA_FB_ADDR_BITS;

  vga_pkg::fb_data_t mem [WORDS];

  // delay line, one stage per cycle of latency
  logic [LATENCY-1:0] rd_busy;
  vga_pkg::fb_data_t  rd_pipe [LATENCY];

  logic rd_accept;

  // single outstanding read
  assign arready   = ~(|rd_busy);
  assign rd_accept = rd_req.arvalid && arready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_busy <= '0;
    end else begin
      rd_busy[0] <= rd_accept;
      for (int i = 1; i < LATENCY; i++) begin
        rd_busy[i] <= rd_busy[i-1];
      end
    end
  end

  // word is sampled at acceptance and shifted along
  always_ff @(posedge clk) begin
    rd_pipe[0] <= mem[rd_req.araddr];
    for (int i = 1; i < LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  always_comb begin
    rd_rsp.rdata  = rd_pipe[LATENCY-1];
    rd_rsp.rvalid = rd_busy[LATENCY-1];
    rd_rsp.rresp  = 2'b00;
  end

  // the master never drops rready, so data is never left hanging
  a_rvalid_needs_rready : assert property (
    @(posedge clk) disable iff (reset) rd_rsp.rvalid |-> rready
  ) else $error("fb_sram: rvalid while rready low");

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t       = logic,
  parameter int  ADDR_BITS       = 3,
  parameter int  ALMOST_FULL_BUF = 2
) (
  input  logic     clk,
  input  logic     reset,

  // write side
  input  logic     w_inc,
  input  payload_t w_data,
  output logic     w_full,
  output logic     w_almost_full,

  // read side, head is visible before the pop
  input  logic     r_inc,
  output payload_t r_data,
  output logic     r_empty
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  localparam logic [ADDR_BITS:0] FULL_LEVEL   = (ADDR_BITS + 1)'(DEPTH);
  localparam logic [ADDR_BITS:0] ALMOST_LEVEL = (ADDR_BITS + 1)'(DEPTH - ALMOST_FULL_BUF);

  payload_t mem [DEPTH];

  // pointers carry one extra wrap bit
  logic [ADDR_BITS:0] w_ptr;
  logic [ADDR_BITS:0] r_ptr;
  logic [ADDR_BITS:0] count;

  assign count = w_ptr - r_ptr;

  assign r_empty       = (w_ptr == r_ptr);
  assign w_full        = (count == FULL_LEVEL);
  assign w_almost_full = (count >= ALMOST_LEVEL);

  assign r_data = mem[r_ptr[ADDR_BITS-1:0]];

  always_ff @(posedge clk) begin
    if (w_inc && !w_full) begin
      mem[w_ptr[ADDR_BITS-1:0]] <= w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      w_ptr <= '0;
    end else if (w_inc && !w_full) begin
      w_ptr <= w_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      r_ptr <= '0;
    end else if (r_inc && !r_empty) begin
      r_ptr <= r_ptr + 1'b1;
    end
  end

  // the writer must respect full, the reader must respect empty
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (reset) !(w_inc && w_full)
  ) else $error("sync_fifo: write while full");

  a_no_read_when_empty : assert property (
    @(posedge clk) disable iff (reset) !(r_inc && r_empty)
  ) else $error("sync_fifo: read while empty");

endmodule

/* logic/vga_fb_pixel_stream.sv */
`timescale 1ns/1ps

`include "vga_config.svh"

module vga_fb_pixel_stream (
  input  logic                  clk,
  input  logic                  reset,

  // plain enable level in, one valid pulse per pixel out
  input  logic                  enable,
  output logic                  valid,
  output vga_pkg::pixel_out_t   pixel,

  // frame buffer read master
  output vga_pkg::fb_read_req_t rd_req,
  input  logic                  arready,
  output logic                  rready,
  input  vga_pkg::fb_read_rsp_t rd_rsp
);

  localparam vga_pkg::fb_addr_t LINE_WORDS = vga_pkg::fb_addr_t'(`VGA_H_VISIBLE);

  typedef enum logic {
    IDLE,
    READING
  } state_t;

  state_t state;
  state_t next_state;

  // raster position
  logic          raster_step;
  logic          pos_visible;
  logic          pos_hsync;
  logic          pos_vsync;
  vga_pkg::col_t pos_column;
  vga_pkg::row_t pos_row;

  // registered address stage
  logic                 p1_new;
  vga_pkg::pixel_ctx_t  p1_ctx;
  vga_pkg::fb_addr_t    p1_addr;
  vga_pkg::fb_addr_t    addr_calc;
  vga_pkg::fb_addr_t    araddr_q;

  logic read_start;
  logic read_accepted;
  logic read_done;
  logic read_stall;

  // context FIFO
  logic                 fifo_almost_full;
  logic                 fifo_empty;
  logic                 fifo_pop;
  vga_pkg::pixel_ctx_t  fifo_head;

  assign read_accepted = rd_req.arvalid && arready;
  assign read_done     = rd_rsp.rvalid && rready;

  // hold the raster while a read still has to leave the address stage
  assign read_stall  = ((state == READING) && !read_accepted) || (p1_new && p1_ctx.visible);
  assign raster_step = enable && !fifo_almost_full && !read_stall;

  vga_sync u_sync (
    .clk    (clk),
    .reset  (reset),
    .step   (raster_step),
    .visible(pos_visible),
    .hsync  (pos_hsync),
    .vsync  (pos_vsync),
    .column (pos_column),
    .row    (pos_row)
  );

  assign addr_calc = vga_pkg::fb_addr_t'(pos_row) * LINE_WORDS
                   + vga_pkg::fb_addr_t'(pos_column);

  always_ff @(posedge clk) begin
    if (reset) begin
      p1_new <= 1'b0;
    end else begin
      p1_new <= raster_step;
    end
  end

  always_ff @(posedge clk) begin
    if (raster_step) begin
      p1_addr        <= addr_calc;
      p1_ctx.visible <= pos_visible;
      p1_ctx.vsync   <= pos_vsync;
      p1_ctx.hsync   <= pos_hsync;
    end
  end

  // one read per visible position; blanking stays idle
  assign read_start = (state == IDLE) && p1_new && p1_ctx.visible;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (read_start) next_state = READING;
      READING: if (read_accepted) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (read_start) begin
      araddr_q <= p1_addr;
    end
  end

  // arvalid holds for the whole READING state
  always_comb begin
    rd_req.araddr  = araddr_q;
    rd_req.arvalid = (state == READING);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rready <= 1'b1;
    end
  end

  sync_fifo #(
    .payload_t      (vga_pkg::pixel_ctx_t),
    .ADDR_BITS      (`VGA_FIFO_ADDR_BITS),
    .ALMOST_FULL_BUF(`VGA_FIFO_ALMOST_FULL_BUF)
  ) u_ctx_fifo (
    .clk          (clk),
    .reset        (reset),
    .w_inc        (p1_new),
    .w_data       (p1_ctx),
    .w_full       (),
    .w_almost_full(fifo_almost_full),
    .r_inc        (fifo_pop),
    .r_data       (fifo_head),
    .r_empty      (fifo_empty)
  );

  // blanking leaves at once, visible waits for its word
  assign fifo_pop = !fifo_empty && (fifo_head.visible ? read_done : 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= fifo_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      pixel.hsync <= fifo_head.hsync;
      pixel.vsync <= fifo_head.vsync;
      {pixel.red, pixel.grn, pixel.blu, pixel.meta} <=
        fifo_head.visible ? rd_rsp.rdata : '0;
    end
  end

  // returned words are matched in order against the context queue
  a_rvalid_meets_visible : assert property (
    @(posedge clk) disable iff (reset) rd_rsp.rvalid |-> (!fifo_empty && fifo_head.visible)
  ) else $error("vga_fb_pixel_stream: rvalid without visible context at FIFO head");

endmodule

/* logic/vga_fb_top.sv */
`timescale 1ns/1ps

module vga_fb_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  output logic                valid,
  output vga_pkg::pixel_out_t pixel,
  input  logic                wr_en,
  input  vga_pkg::fb_addr_t   wr_addr,
  input  vga_pkg::fb_data_t   wr_data
);

  // read channel between streamer and frame buffer
  vga_pkg::fb_read_req_t rd_req;
  vga_pkg::fb_read_rsp_t rd_rsp;
  logic                  arready;
  logic                  rready;

  vga_fb_pixel_stream u_stream (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .valid  (valid),
    .pixel  (pixel),
    .rd_req (rd_req),
    .arready(arready),
    .rready (rready),
    .rd_rsp (rd_rsp)
  );

  fb_sram u_fb (
    .clk    (clk),
    .reset  (reset),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_req (rd_req),
    .arready(arready),
    .rready (rready),
    .rd_rsp (rd_rsp)
  );

endmodule

/* logic/vga_pkg.sv */
`include "vga_config.svh"

package vga_pkg;

  // frame buffer address and word
  typedef logic [`VGA_FB_ADDR_BITS-1:0] fb_addr_t;
  typedef logic [`VGA_FB_DATA_BITS-1:0] fb_data_t;

  // raster counters, wide enough for the whole line and frame
  typedef logic [$clog2(`VGA_H_WHOLE_LINE)-1:0]  col_t;
  typedef logic [$clog2(`VGA_V_WHOLE_FRAME)-1:0] row_t;

  // one colour channel, also used for the meta nibble
  typedef logic [3:0] color_t;

  // context of one raster position, carried alongside its read
  typedef struct packed {
    logic visible;
    logic vsync;
    logic hsync;
  } pixel_ctx_t;

  // one output pixel; colour order matches the frame buffer word
  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
    color_t meta;
    logic   hsync;
    logic   vsync;
  } pixel_out_t;

  // read address channel
  typedef struct packed {
    fb_addr_t araddr;
    logic     arvalid;
  } fb_read_req_t;

  // read data channel
  typedef struct packed {
    fb_data_t   rdata;
    logic       rvalid;
    logic [1:0] rresp;
  } fb_read_rsp_t;

endpackage

/* logic/vga_sync.sv */
`timescale 1ns/1ps

`include "vga_config.svh"

module vga_sync (
  input  logic          clk,
  input  logic          reset,
  input  logic          step,
  output logic          visible,
  output logic          hsync,
  output logic          vsync,
  output vga_pkg::col_t column,
  output vga_pkg::row_t row
);

  localparam vga_pkg::col_t H_VISIBLE = vga_pkg::col_t'(`VGA_H_VISIBLE);
  localparam vga_pkg::col_t H_LAST    = vga_pkg::col_t'(`VGA_H_WHOLE_LINE - 1);
  localparam vga_pkg::row_t V_VISIBLE = vga_pkg::row_t'(`VGA_V_VISIBLE);
  localparam vga_pkg::row_t V_LAST    = vga_pkg::row_t'(`VGA_V_WHOLE_FRAME - 1);

  // sync pulses start right after the front porch
  localparam vga_pkg::col_t H_SYNC_START =
    vga_pkg::col_t'(`VGA_H_VISIBLE + `VGA_H_FRONT_PORCH);
  localparam vga_pkg::col_t H_SYNC_END =
    vga_pkg::col_t'(`VGA_H_VISIBLE + `VGA_H_FRONT_PORCH + `VGA_H_SYNC_PULSE);
  localparam vga_pkg::row_t V_SYNC_START =
    vga_pkg::row_t'(`VGA_V_VISIBLE + `VGA_V_FRONT_PORCH);
  localparam vga_pkg::row_t V_SYNC_END =
    vga_pkg::row_t'(`VGA_V_VISIBLE + `VGA_V_FRONT_PORCH + `VGA_V_SYNC_PULSE);

  logic line_end;

  assign line_end = (column == H_LAST);

  // column counter
  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
    end else if (step) begin
      if (line_end) begin
        column <= '0;
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  // row moves only when the line wraps
  always_ff @(posedge clk) begin
    if (reset) begin
      row <= '0;
    end else if (step && line_end) begin
      if (row == V_LAST) begin
        row <= '0;
      end else begin
        row <= row + 1'b1;
      end
    end
  end

  // region decode, straight from the counters
  assign visible = (column < H_VISIBLE) && (row < V_VISIBLE);
  assign hsync   = (column >= H_SYNC_START) && (column < H_SYNC_END);
  assign vsync   = (row >= V_SYNC_START) && (row < V_SYNC_END);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the scan-out testbench, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module vga_fb_tb -o vga_fb_sim || exit 1
out=$(./obj_dir/vga_fb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

/* sim.f */
+incdir+include
logic/vga_pkg.sv
logic/sync_fifo.sv
logic/vga_sync.sv
logic/fb_sram.sv
logic/vga_fb_pixel_stream.sv
logic/vga_fb_top.sv
testbench/vga_fb_tb.sv

/* testbench/vga_fb_tb.sv */
`timescale 1ns/1ps

`include "vga_config.svh"

module vga_fb_tb;

  localparam int NUM_TESTS = 6;
  localparam int FB_WORDS  = 2 ** `VGA_FB_ADDR_BITS;
  localparam int QUIET_GAP = 12;
  localparam int PAUSE_LEN = 10;

  localparam int H_SYNC_FIRST = `VGA_H_VISIBLE + `VGA_H_FRONT_PORCH;
  localparam int V_SYNC_FIRST = `VGA_V_VISIBLE + `VGA_V_FRONT_PORCH;

  localparam logic [1:0] MODE_STEADY = 2'd0;
  localparam logic [1:0] MODE_RANDOM = 2'd1;
  localparam logic [1:0] MODE_PAUSE  = 2'd2;

  // one row of the stimulus table
  typedef struct packed {
    logic [1:0]  mode;
    logic [3:0]  pause_col;
    logic [15:0] pixels;
    logic        start_reset;
  } test_entry_t;

  logic                clk;
  logic                reset;
  logic                enable;
  logic                valid;
  vga_pkg::pixel_out_t pixel;
  logic                wr_en;
  vga_pkg::fb_addr_t   wr_addr;
  vga_pkg::fb_data_t   wr_data;

  test_entry_t       test_table [NUM_TESTS];
  string             test_name [NUM_TESTS];
  vga_pkg::fb_data_t fb_model [FB_WORDS];

  integer seed         = 32'h947e753a;
  int     cur_test     = 0;
  int     pixel_count  = 0;
  int     error_count  = 0;
  int     failed_tests = 0;
  int     ref_col      = 0;
  int     ref_row      = 0;
  logic   filling      = 1'b0;

  vga_fb_top u_dut (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .valid  (valid),
    .pixel  (pixel),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_table();
    test_table[0] = '{MODE_STEADY, 4'd0, 16'd84, 1'b1};
    test_name[0]  = "full_frame";
    test_table[1] = '{MODE_RANDOM, 4'd0, 16'd84, 1'b1};
    test_name[1]  = "random_enable";
    test_table[2] = '{MODE_PAUSE, 4'd4, 16'd84, 1'b1};
    test_name[2]  = "pause_mid_line";
    test_table[3] = '{MODE_STEADY, 4'd0, 16'd168, 1'b1};
    test_name[3]  = "two_frames";
    // carries on from wherever the raster stopped
    test_table[4] = '{MODE_STEADY, 4'd0, 16'd30, 1'b0};
    test_name[4]  = "run_on";
    test_table[5] = '{MODE_STEADY, 4'd0, 16'd40, 1'b1};
    test_name[5]  = "reset_restart";
  endtask

  function automatic int table_pixel_total();
    int total;
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += int'(test_table[t].pixels);
    end
    return total;
  endfunction

  // reference raster model, one position per output pixel
  function automatic vga_pkg::pixel_out_t expected_pixel(input int col, input int row);
    vga_pkg::pixel_out_t p;
    vga_pkg::fb_data_t   word;
    logic                in_view;
    in_view = (col < `VGA_H_VISIBLE) && (row < `VGA_V_VISIBLE);
    word    = in_view ? fb_model[row * `VGA_H_VISIBLE + col] : '0;
    p.red   = word[15:12];
    p.grn   = word[11:8];
    p.blu   = word[7:4];
    p.meta  = word[3:0];
    p.hsync = (col >= H_SYNC_FIRST) && (col < H_SYNC_FIRST + `VGA_H_SYNC_PULSE);
    p.vsync = (row >= V_SYNC_FIRST) && (row < V_SYNC_FIRST + `VGA_V_SYNC_PULSE);
    return p;
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) wait_cycle();
    reset = 1'b0;
  endtask

  task automatic fill_frame_buffer();
    logic [31:0] rnd;
    filling = 1'b1;
    for (int a = 0; a < FB_WORDS; a++) begin
      rnd         = $random(seed);
      wr_en       = 1'b1;
      wr_addr     = vga_pkg::fb_addr_t'(a);
      wr_data     = rnd[`VGA_FB_DATA_BITS-1:0];
      fb_model[a] = rnd[`VGA_FB_DATA_BITS-1:0];
      wait_cycle();
    end
    wr_en   = 1'b0;
    filling = 1'b0;
  endtask

  // wait until the pipeline has gone quiet after enable drops
  task automatic drain_pipeline();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_GAP) begin
      wait_cycle();
      if (valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic run_test(input int t);
    int          start_pixels;
    int          start_errors;
    int          pause_left;
    int          paused_row;
    int          errs;
    logic [31:0] rnd;
    cur_test = t;
    if (test_table[t].start_reset) begin
      apply_reset();
    end
    fill_frame_buffer();
    start_pixels = pixel_count;
    start_errors = error_count;
    pause_left   = 0;
    paused_row   = -1;
    while (pixel_count - start_pixels < int'(test_table[t].pixels)) begin
      case (test_table[t].mode)
        MODE_RANDOM: begin
          rnd    = $random(seed);
          enable = rnd[0];
        end
        MODE_PAUSE: begin
          // once per line, stop while that line's reads are still in flight
          if (pause_left == 0 && ref_col == int'(test_table[t].pause_col) &&
              ref_row != paused_row) begin
            pause_left = PAUSE_LEN;
            paused_row = ref_row;
          end
          enable = (pause_left == 0);
          if (pause_left > 0) begin
            pause_left--;
          end
        end
        default: enable = 1'b1;
      endcase
      wait_cycle();
    end
    enable = 1'b0;
    drain_pipeline();
    errs = error_count - start_errors;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %0d %s: %0d pixels checked, %0d errors", t, test_name[t],
             pixel_count - start_pixels, errs);
  endtask

  // checks every pixel the DUT emits against the reference raster
  always @(negedge clk) begin : monitor
    vga_pkg::pixel_out_t expected;
    if (reset) begin
      ref_col = 0;
      ref_row = 0;
    end else if (valid === 1'b1) begin
      expected = expected_pixel(ref_col, ref_row);
      if (filling) begin
        $display("error in %s: a pixel came out while the frame buffer was being filled",
                 test_name[cur_test]);
        error_count++;
      end
      if (pixel !== expected) begin
        $display("Mismatch in %s at row %0d column %0d: expected %h, actual %h",
                 test_name[cur_test], ref_row, ref_col, expected, pixel);
        error_count++;
      end
      pixel_count++;
      if (ref_col == `VGA_H_WHOLE_LINE - 1) begin
        ref_col = 0;
        ref_row = (ref_row == `VGA_V_WHOLE_FRAME - 1) ? 0 : ref_row + 1;
      end else begin
        ref_col++;
      end
    end
  end

  initial begin : watchdog
    int limit;
    int cycles;
    @(posedge clk);
    limit  = 20 * table_pixel_total();
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    reset   = 1'b0;
    enable  = 1'b0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    load_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("summary: %0d tests, %0d failed, %0d pixels checked, %0d errors",
             NUM_TESTS, failed_tests, pixel_count, error_count);
    if (error_count == 0 && failed_tests == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
